// File: include/ppu_defs.svh
// Post-processing output unit definitions
// Widths, config word layout, video mode codes and range-limit constants
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// ========================================
// Widths
// ========================================
`define PPU_COLOR_W   8   // Bits per color
`define PPU_VD_W      24  // RGB word
`define PPU_CFG_W     32  // Static config word
`define PPU_VIDX_W    3   // Resolution index in vmode
`define PPU_SL_STR_W  4   // Scanline strength code

// ========================================
// Config word bit positions
// ========================================
`define PPU_CFG_RES_LSB        0   // Target resolution, 2 bits
`define PPU_CFG_RES_MSB        1
`define PPU_CFG_VGA_BIT        2   // VGA instead of 480p
`define PPU_CFG_F60_BIT        3   // Force 60 Hz
`define PPU_CFG_F50_BIT        4   // Force 50 Hz
`define PPU_CFG_LLM_BIT        5   // Low-latency mode
`define PPU_CFG_LIMRGB_BIT     6   // Limited-range RGB output
`define PPU_CFG_SL240_EN_BIT   8
`define PPU_CFG_SL240_STR_LSB  9   // 4 bits
`define PPU_CFG_SL480_EN_BIT   16
`define PPU_CFG_SL480_STR_LSB  17  // 4 bits
`define PPU_CFG_SL480_LINK_BIT 21  // 480i strength follows 240p
`define PPU_CFG_480I_BIT       24  // Input is interlaced

// ========================================
// Mode codes
// ========================================
// Target resolution field
`define PPU_RES_480P   2'd0
`define PPU_RES_720P   2'd1
`define PPU_RES_1080P  2'd2
`define PPU_RES_1200P  2'd3

// Resolution index inside vmode, 480p and 576p share index 0
`define PPU_VIDX_480P  3'd0
`define PPU_VIDX_VGA   3'd1
`define PPU_VIDX_720P  3'd2
`define PPU_VIDX_1080P 3'd3
`define PPU_VIDX_1200P 3'd4

`define PPU_VMODE_480P60 4'h0  // Reset mode

// ========================================
// Range limit and resync
// ========================================
`define PPU_LIM_COEFF  8'd220  // 235 - 16 + 1
`define PPU_LIM_OFFSET 8'd16
`define PPU_LIM_MIN    8'd16   // Lowest limited level
`define PPU_LIM_MAX    8'd235  // Offset + coeff - 1

`define PPU_SYNC_STAGES 2  // Flops on the config resync

`endif

// File: design/ppu_pkg.sv
// Post-processing output unit types
// Video mode word with raw and decoded views, scanline settings
`include "ppu_defs.svh"

package ppu_pkg;

  // Decoded view of the video mode
  typedef struct packed {
    logic                    f50;      // 50 Hz family
    logic [`PPU_VIDX_W-1:0]  res_idx;  // 0 480p/576p, 1 VGA, 2 720p, 3 1080p, 4 1200p
  } vmode_s_t;

  // Same 4-bit word seen as a raw code or split into rate and resolution
  typedef union packed {
    logic [`PPU_VIDX_W:0] vmode_raw;  // Raw mode code as written by control
    vmode_s_t             mode_s;     // Field view used for sync polarity
  } vmode_u;

  // Scanline settings handed to the datapath
  typedef struct packed {
    logic                    en;   // Scanlines on
    logic [`PPU_COLOR_W-1:0] str;  // Darkening factor, 255 = full
  } sl_cfg_t;

endpackage

// File: design/ppu_cfg_ctrl.sv
// Output control for the post-processing unit
// Resyncs config word and PAL flag, registers video mode, sync polarity,
// scanline settings and limited-range flag
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_cfg_ctrl (
  input  logic                   VCLK_Tx,
  input  logic                   nVRST_Tx,
  input  logic [`PPU_CFG_W-1:0]  config_word_i,
  input  logic                   pal_mode_i,
  output ppu_pkg::vmode_u        vmode_o,
  output logic                   hsync_pos_o,
  output logic                   vsync_pos_o,
  output ppu_pkg::sl_cfg_t       sl_cfg_o,
  output logic                   lim_rgb_o
);

  // ========================================
  // Resync into VCLK_Tx
  // ========================================
  logic [`PPU_SYNC_STAGES-1:0][`PPU_CFG_W-1:0] cfg_sync_q;
  logic [`PPU_SYNC_STAGES-1:0]                 pal_sync_q;
  logic [`PPU_CFG_W-1:0]                       cfg_rs;  // Resynced config
  logic                                        pal_rs;  // Resynced PAL flag

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_sync_q <= '0;
      pal_sync_q <= '0;
    end else begin
      cfg_sync_q <= {cfg_sync_q[`PPU_SYNC_STAGES-2:0], config_word_i};  // Shift in
      pal_sync_q <= {pal_sync_q[`PPU_SYNC_STAGES-2:0], pal_mode_i};
    end
  end

  assign cfg_rs = cfg_sync_q[`PPU_SYNC_STAGES-1];
  assign pal_rs = pal_sync_q[`PPU_SYNC_STAGES-1];

  // ========================================
  // Video mode decode
  // ========================================
  logic [1:0]             res_sel;
  logic                   llm;
  logic                   use_50hz;
  logic [`PPU_VIDX_W-1:0] idx_60;
  logic [`PPU_VIDX_W-1:0] idx_50;
  ppu_pkg::vmode_u        vmode_d;
  logic                   sync_pos_d;

  assign res_sel = cfg_rs[`PPU_CFG_RES_MSB:`PPU_CFG_RES_LSB];
  assign llm     = cfg_rs[`PPU_CFG_LLM_BIT];

  // Forcing a rate only counts outside low-latency mode
  assign use_50hz = (cfg_rs[`PPU_CFG_F60_BIT] & !llm) ? 1'b0 :
                    (cfg_rs[`PPU_CFG_F50_BIT] & !llm) ? 1'b1 :
                                                        pal_rs;

  always_comb begin
    case (res_sel)
      `PPU_RES_720P:  idx_60 = `PPU_VIDX_720P;
      `PPU_RES_1080P: idx_60 = `PPU_VIDX_1080P;
      `PPU_RES_1200P: idx_60 = `PPU_VIDX_1200P;
      default:        idx_60 = cfg_rs[`PPU_CFG_VGA_BIT] ? `PPU_VIDX_VGA :
                                                          `PPU_VIDX_480P;
    endcase
    // No VGA at 50 Hz, 480p turns into 576p
    case (res_sel)
      `PPU_RES_720P:  idx_50 = `PPU_VIDX_720P;
      `PPU_RES_1080P: idx_50 = `PPU_VIDX_1080P;
      `PPU_RES_1200P: idx_50 = `PPU_VIDX_1200P;
      default:        idx_50 = `PPU_VIDX_480P;
    endcase
  end

  always_comb begin
    vmode_d.vmode_raw = {use_50hz, use_50hz ? idx_50 : idx_60};
  end

  // HD modes use positive sync, SD and VGA negative
  assign sync_pos_d = (vmode_d.mode_s.res_idx >= `PPU_VIDX_720P);

  // ========================================
  // Scanline settings
  // ========================================
  logic                     is_480i;
  logic [`PPU_SL_STR_W-1:0] sl_code;  // 4-bit strength as configured
  ppu_pkg::sl_cfg_t         sl_cfg_d;

  assign is_480i = cfg_rs[`PPU_CFG_480I_BIT];

  always_comb begin
    if (!is_480i) begin
      sl_cfg_d.en = cfg_rs[`PPU_CFG_SL240_EN_BIT];
      sl_code     = cfg_rs[`PPU_CFG_SL240_STR_LSB +: `PPU_SL_STR_W];
    end else begin
      sl_cfg_d.en = cfg_rs[`PPU_CFG_SL480_EN_BIT];  // Enable is always the 480i one
      if (cfg_rs[`PPU_CFG_SL480_LINK_BIT])
        sl_code = cfg_rs[`PPU_CFG_SL240_STR_LSB +: `PPU_SL_STR_W];
      else
        sl_code = cfg_rs[`PPU_CFG_SL480_STR_LSB +: `PPU_SL_STR_W];
    end
    sl_cfg_d.str = {sl_code, 4'hF};  // 16*(code+1)-1
  end

  // ========================================
  // Output registers
  // ========================================
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vmode_o.vmode_raw <= `PPU_VMODE_480P60;
      hsync_pos_o       <= 1'b0;  // 480p is negative
      vsync_pos_o       <= 1'b0;
      sl_cfg_o          <= '0;
      lim_rgb_o         <= 1'b0;
    end else begin
      vmode_o     <= vmode_d;
      hsync_pos_o <= sync_pos_d;
      vsync_pos_o <= sync_pos_d;
      sl_cfg_o    <= sl_cfg_d;
      lim_rgb_o   <= cfg_rs[`PPU_CFG_LIMRGB_BIT];
    end
  end

  // Only five resolutions exist
  a_vmode_legal: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    vmode_o.mode_s.res_idx <= `PPU_VIDX_1200P);

endmodule

// File: design/scanline_emu.sv
// Scanline emulation
// Darkens pixels on scanline rows by the set strength, syncs follow one cycle later
`timescale 1ns/1ps
`include "ppu_defs.svh"

module scanline_emu (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  logic                  hsync_i,
  input  logic                  vsync_i,
  input  logic                  de_i,
  input  logic                  draw_sl_i,
  input  logic [`PPU_VD_W-1:0]  vd_i,
  input  ppu_pkg::sl_cfg_t      sl_cfg_i,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  de_o,
  output logic [`PPU_VD_W-1:0]  vd_o
);

  localparam int unsigned W    = `PPU_COLOR_W;
  localparam int unsigned NCOL = `PPU_VD_W / `PPU_COLOR_W;  // R, G, B

  logic                 darken;  // Pixel sits on a visible scanline row
  logic [`PPU_VD_W-1:0] vd_sl;   // Color after darkening

  assign darken = sl_cfg_i.en & draw_sl_i & de_i;

  // ========================================
  // Per color darkening
  // ========================================
  for (genvar c = 0; c < NCOL; c++) begin : g_col
    logic [2*W-1:0] prod;  // Color times strength

    assign prod = vd_i[c*W +: W] * sl_cfg_i.str;
    // Subtract c*str/256, never goes below zero
    assign vd_sl[c*W +: W] = darken ? vd_i[c*W +: W] - prod[2*W-1:W] :
                                      vd_i[c*W +: W];

    // Scanlines only ever take light away
    a_sl_never_brighter: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      vd_o[c*W +: W] <= $past(vd_i[c*W +: W]));
  end

  // Syncs and DE ride along with the color
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vd_o    <= '0;
    end else begin
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
      de_o    <= de_i;
      vd_o    <= vd_sl;
    end
  end

endmodule

// File: design/rgb_range_out.sv
// Final output stage
// Three register stages with optional limited-range RGB and sync polarity
`timescale 1ns/1ps
`include "ppu_defs.svh"

module rgb_range_out (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  logic                  hsync_i,      // Active high
  input  logic                  vsync_i,      // Active high
  input  logic                  de_i,
  input  logic [`PPU_VD_W-1:0]  vd_i,
  input  logic                  lim_rgb_i,
  input  logic                  hsync_pos_i,
  input  logic                  vsync_pos_i,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  de_o,
  output logic [`PPU_VD_W-1:0]  vd_o
);

  localparam int unsigned W    = `PPU_COLOR_W;
  localparam int unsigned NCOL = `PPU_VD_W / `PPU_COLOR_W;

  logic [1:0]                hsync_q;  // Stage 1 and 2
  logic [1:0]                vsync_q;
  logic [1:0]                de_q;
  logic [1:0][`PPU_VD_W-1:0] full_q;   // Full range color, stage 1 and 2
  logic [`PPU_VD_W-1:0]      lim_vd;   // Limited color ready for stage 3

  // ========================================
  // Limited range per color
  // ========================================
  for (genvar c = 0; c < NCOL; c++) begin : g_col
    logic [2*W-1:0] lim_prod;
    logic [W:0]     lim_s1_q;  // Top 9 bits of c*220
    logic [W-1:0]   lim_s2_q;  // Rounded c*220/256

    assign lim_prod = vd_i[c*W +: W] * `PPU_LIM_COEFF;

    always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
      if (!nVRST_Tx) begin
        lim_s1_q <= '0;
        lim_s2_q <= '0;
      end else begin
        lim_s1_q <= lim_prod[2*W-1:W-1];
        lim_s2_q <= lim_s1_q[W:1] + W'(lim_s1_q[0]);  // Round up on half LSB
      end
    end

    assign lim_vd[c*W +: W] = lim_s2_q + `PPU_LIM_OFFSET;  // Max 219 + 16

    // Limited output stays in the video levels
    a_lim_in_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(lim_rgb_i) |-> vd_o[c*W +: W] inside {[`PPU_LIM_MIN:`PPU_LIM_MAX]});
  end

  // ========================================
  // Pipeline and output registers
  // ========================================
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      hsync_q <= '0;
      vsync_q <= '0;
      de_q    <= '0;
      full_q  <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vd_o    <= '0;
    end else begin
      hsync_q <= {hsync_q[0], hsync_i};
      vsync_q <= {vsync_q[0], vsync_i};
      de_q    <= {de_q[0], de_i};
      full_q  <= {full_q[0], vd_i};
      hsync_o <= hsync_q[1] ^ ~hsync_pos_i;  // Invert for negative polarity
      vsync_o <= vsync_q[1] ^ ~vsync_pos_i;
      de_o    <= de_q[1];
      vd_o    <= lim_rgb_i ? lim_vd : full_q[1];
    end
  end

endmodule

// File: design/ppu_out_top.sv
// Post-processing output unit top
// Control block plus scanline and output range datapath, 4 cycles in to out
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_out_top (
  input  logic                  VCLK_Tx,
  input  logic                  nVRST_Tx,
  input  logic [`PPU_CFG_W-1:0] config_word_i,
  input  logic                  pal_mode_i,
  input  logic                  hsync_i,
  input  logic                  vsync_i,
  input  logic                  de_i,
  input  logic                  draw_sl_i,   // Current row is a scanline
  input  logic [`PPU_VD_W-1:0]  vd_i,
  output logic                  hsync_o,
  output logic                  vsync_o,
  output logic                  de_o,
  output logic [`PPU_VD_W-1:0]  vd_o,
  output ppu_pkg::vmode_u       vmode_o
);

  // Control levels, static between config changes
  logic             hsync_pos;
  logic             vsync_pos;
  logic             lim_rgb;
  ppu_pkg::sl_cfg_t sl_cfg;

  // Scanline stage to output stage
  logic                 sl_hsync;
  logic                 sl_vsync;
  logic                 sl_de;
  logic [`PPU_VD_W-1:0] sl_vd;

  ppu_cfg_ctrl cfg_ctrl_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .config_word_i (config_word_i),
    .pal_mode_i    (pal_mode_i),
    .vmode_o       (vmode_o),
    .hsync_pos_o   (hsync_pos),
    .vsync_pos_o   (vsync_pos),
    .sl_cfg_o      (sl_cfg),
    .lim_rgb_o     (lim_rgb)
  );

  // 1 cycle
  scanline_emu scanline_emu_u (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .hsync_i   (hsync_i),
    .vsync_i   (vsync_i),
    .de_i      (de_i),
    .draw_sl_i (draw_sl_i),
    .vd_i      (vd_i),
    .sl_cfg_i  (sl_cfg),
    .hsync_o   (sl_hsync),
    .vsync_o   (sl_vsync),
    .de_o      (sl_de),
    .vd_o      (sl_vd)
  );

  // 3 cycles
  rgb_range_out rgb_range_out_u (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .hsync_i     (sl_hsync),
    .vsync_i     (sl_vsync),
    .de_i        (sl_de),
    .vd_i        (sl_vd),
    .lim_rgb_i   (lim_rgb),
    .hsync_pos_i (hsync_pos),
    .vsync_pos_i (vsync_pos),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .de_o        (de_o),
    .vd_o        (vd_o)
  );

endmodule

// File: test/ppu_out_tb.sv
// Testbench for the post-processing output unit
// LFSR video stimulus, 4-cycle reference pipeline and checking assertions
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_out_tb;

  localparam int CFG_LAT     = `PPU_SYNC_STAGES + 1;  // Config to control outputs
  localparam int CFG_TIMEOUT = 20;

  logic                  VCLK_Tx   = 1'b0;
  logic                  nVRST_Tx;
  logic [`PPU_CFG_W-1:0] config_word_i;
  logic                  pal_mode_i;
  logic                  hsync_i   = 1'b0;
  logic                  vsync_i   = 1'b0;
  logic                  de_i      = 1'b0;
  logic                  draw_sl_i = 1'b0;
  logic [`PPU_VD_W-1:0]  vd_i      = '0;
  logic                  hsync_o;
  logic                  vsync_o;
  logic                  de_o;
  logic [`PPU_VD_W-1:0]  vd_o;
  ppu_pkg::vmode_u       vmode_o;

  // ========================================
  // Reference pipeline, index 3 lines up with the outputs
  // ========================================
  logic [3:0][`PPU_VD_W-1:0] exp_vd_q = '0;
  logic [3:0]  exp_de_q = '0;
  logic [3:0]  exp_hs_q = '0;
  logic [3:0]  exp_vs_q = '0;
  logic [3:0]  exp_ok_q = '0;    // Pixel entered under a settled config
  logic [3:0]  exp_mode;
  logic        model_ok = 1'b0;
  logic        idle     = 1'b1;  // Reset and the quiet cycles after it
  logic        run      = 1'b0;
  logic [15:0] lfsr_q   = 16'd23;
  int          cyc         = 0;
  int          err_reset   = 0;
  int          err_mode    = 0;
  int          err_sync    = 0;
  int          err_video   = 0;
  int          err_timeout = 0;
  string       test_name   = "reset";

  ppu_out_top dut_i (.*);

  always #50 VCLK_Tx = ~VCLK_Tx;  // 100 ns period

  // Mode from the rate and resolution rules
  function automatic logic [3:0] mode_rule(input logic [31:0] cfg, input logic pal);
    logic       llm;
    logic       f50;
    logic [2:0] idx;
    llm = cfg[`PPU_CFG_LLM_BIT];
    if (!llm && cfg[`PPU_CFG_F60_BIT])
      f50 = 1'b0;
    else if (!llm && cfg[`PPU_CFG_F50_BIT])
      f50 = 1'b1;
    else
      f50 = pal;  // Low latency follows the source
    case (cfg[`PPU_CFG_RES_MSB:`PPU_CFG_RES_LSB])
      `PPU_RES_720P:  idx = `PPU_VIDX_720P;
      `PPU_RES_1080P: idx = `PPU_VIDX_1080P;
      `PPU_RES_1200P: idx = `PPU_VIDX_1200P;
      default:        idx = (cfg[`PPU_CFG_VGA_BIT] && !f50) ? `PPU_VIDX_VGA : `PPU_VIDX_480P;
    endcase
    return {f50, idx};
  endfunction

  // Scanline darkening then optional limited range, per color
  function automatic logic [23:0] color_rule(input logic [23:0] vd, input logic de,
                                             input logic draw, input logic [31:0] cfg);
    logic [23:0] res;
    logic        is_480i;
    logic        en;
    int          code;
    int          str;
    int          x;
    int          c;
    is_480i = cfg[`PPU_CFG_480I_BIT];
    en      = is_480i ? cfg[`PPU_CFG_SL480_EN_BIT] : cfg[`PPU_CFG_SL240_EN_BIT];
    if (is_480i && !cfg[`PPU_CFG_SL480_LINK_BIT])
      code = int'(cfg[`PPU_CFG_SL480_STR_LSB +: 4]);
    else
      code = int'(cfg[`PPU_CFG_SL240_STR_LSB +: 4]);
    str = 16 * (code + 1) - 1;
    res = '0;
    for (c = 0; c < 3; c++) begin
      x = int'(vd[c*8 +: 8]);
      if (en && draw && de)
        x = x - (x * str) / 256;
      if (cfg[`PPU_CFG_LIMRGB_BIT])
        x = (x * 220 + 128) / 256 + 16;  // Rounded scale into 16..235
      res[c*8 +: 8] = 8'(x);
    end
    return res;
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // New config, wait for the mode to land, then let pixels run
  task automatic run_with_config(input logic [31:0] cfg, input logic pal, input int n);
    logic [3:0] want;
    int         waited;
    want   = mode_rule(cfg, pal);
    waited = 0;
    @(posedge VCLK_Tx);
    config_word_i <= cfg;
    pal_mode_i    <= pal;
    model_ok      <= 1'b0;
    do begin
      @(negedge VCLK_Tx);
      waited++;
    end while (!(waited > CFG_LAT && vmode_o.vmode_raw == want) && waited < CFG_TIMEOUT);
    if (vmode_o.vmode_raw != want) begin
      err_timeout++;
      $display("Timeout in %s, vmode_o never settled on the new mode", test_name);
    end
    @(posedge VCLK_Tx);
    model_ok <= 1'b1;
    repeat (n) @(posedge VCLK_Tx);
  endtask

  always @(posedge VCLK_Tx) begin : drive_video
    logic [31:0] r;
    logic        pos;
    pos = (exp_mode[2:0] >= `PPU_VIDX_720P);  // HD keeps positive sync
    cyc      <= cyc + 1;
    exp_vd_q <= {exp_vd_q[2:0], color_rule(vd_i, de_i, draw_sl_i, config_word_i)};
    exp_de_q <= {exp_de_q[2:0], de_i};
    exp_hs_q <= {exp_hs_q[2:0], hsync_i ^ !pos};
    exp_vs_q <= {exp_vs_q[2:0], vsync_i ^ !pos};
    exp_ok_q <= {exp_ok_q[2:0], model_ok};
    r = '0;
    if (run)
      take_bits(28, r);  // Color, then hs, vs, de, draw_sl
    vd_i <= r[23:0];
    {hsync_i, vsync_i, de_i, draw_sl_i} <= r[27:24];
  end

  assign exp_mode = mode_rule(config_word_i, pal_mode_i);

  // ========================================
  // Checks
  // ========================================
  a_reset: assert property (@(posedge VCLK_Tx) (cyc > 0 && idle) |->
    (!de_o && vd_o == '0 && vmode_o.vmode_raw == `PPU_VMODE_480P60 &&
     (nVRST_Tx || (!hsync_o && !vsync_o))))
    else begin
      err_reset++;
      $display("ERROR reset: expected de/vd/vmode 0/000000/0 actual %b/%h/%h",
               $sampled(de_o), $sampled(vd_o), $sampled(vmode_o.vmode_raw));
    end

  a_mode: assert property (@(posedge VCLK_Tx) model_ok |-> vmode_o.vmode_raw == exp_mode)
    else begin
      err_mode++;
      $display("ERROR %s: vmode_o expected %h actual %h", test_name,
               $sampled(exp_mode), $sampled(vmode_o.vmode_raw));
    end

  a_sync: assert property (@(posedge VCLK_Tx) exp_ok_q[3] |->
    {hsync_o, vsync_o} == {exp_hs_q[3], exp_vs_q[3]})
    else begin
      err_sync++;
      $display("ERROR %s: hsync/vsync expected %b%b actual %b%b", test_name,
               $sampled(exp_hs_q[3]), $sampled(exp_vs_q[3]),
               $sampled(hsync_o), $sampled(vsync_o));
    end

  a_video: assert property (@(posedge VCLK_Tx) exp_ok_q[3] |->
    {de_o, vd_o} == {exp_de_q[3], exp_vd_q[3]})
    else begin
      err_video++;
      $display("ERROR %s: de/vd expected %b/%h actual %b/%h", test_name,
               $sampled(exp_de_q[3]), $sampled(exp_vd_q[3]), $sampled(de_o), $sampled(vd_o));
    end

  initial begin
    logic [31:0] cfg;
    int          k;
    int          total;
    nVRST_Tx      = 1'b0;
    config_word_i = '0;
    pal_mode_i    = 1'b0;
    repeat (4) @(posedge VCLK_Tx);
    nVRST_Tx <= 1'b1;
    model_ok <= 1'b1;  // Config 0 is the reset mode
    repeat (8) @(posedge VCLK_Tx);
    idle <= 1'b0;
    run  <= 1'b1;

    // Rate and resolution sweep without both forces set
    test_name = "mode";
    for (k = 0; k < 128; k++) begin
      if (!(k[3] && k[4])) begin
        cfg = '0;
        cfg[`PPU_CFG_RES_MSB:`PPU_CFG_RES_LSB] = k[1:0];
        cfg[`PPU_CFG_VGA_BIT] = k[2];
        cfg[`PPU_CFG_F60_BIT] = k[3];
        cfg[`PPU_CFG_F50_BIT] = k[4];
        cfg[`PPU_CFG_LLM_BIT] = k[5];
        run_with_config(cfg, k[6], 6);
      end
    end

    test_name = "scanline_240p";
    cfg = '0;
    cfg[`PPU_CFG_SL240_EN_BIT]       = 1'b1;
    cfg[`PPU_CFG_SL240_STR_LSB +: 4] = 4'd7;
    run_with_config(cfg, 1'b0, 40);
    cfg[`PPU_CFG_SL240_STR_LSB +: 4] = 4'd15;  // Strongest setting
    run_with_config(cfg, 1'b0, 40);
    test_name = "scanline_480i_linked";
    cfg[`PPU_CFG_SL240_EN_BIT]       = 1'b0;  // Only the 480i enable counts
    cfg[`PPU_CFG_SL240_STR_LSB +: 4] = 4'd3;
    cfg[`PPU_CFG_480I_BIT]           = 1'b1;
    cfg[`PPU_CFG_SL480_EN_BIT]       = 1'b1;
    cfg[`PPU_CFG_SL480_STR_LSB +: 4] = 4'd12;
    cfg[`PPU_CFG_SL480_LINK_BIT]     = 1'b1;
    run_with_config(cfg, 1'b0, 40);
    test_name = "scanline_480i";
    cfg[`PPU_CFG_SL480_LINK_BIT] = 1'b0;
    run_with_config(cfg, 1'b0, 40);

    test_name = "limited";
    cfg = '0;
    cfg[`PPU_CFG_LIMRGB_BIT] = 1'b1;
    run_with_config(cfg, 1'b0, 40);
    cfg[`PPU_CFG_RES_MSB:`PPU_CFG_RES_LSB] = `PPU_RES_720P;  // Positive sync at 50 Hz
    run_with_config(cfg, 1'b1, 40);
    cfg[`PPU_CFG_SL240_EN_BIT]       = 1'b1;
    cfg[`PPU_CFG_SL240_STR_LSB +: 4] = 4'd10;
    run_with_config(cfg, 1'b0, 40);
    test_name = "full_range";
    cfg[`PPU_CFG_LIMRGB_BIT] = 1'b0;
    run_with_config(cfg, 1'b0, 20);

    total = err_reset + err_mode + err_sync + err_video + err_timeout;
    $display("Errors: reset %0d, mode %0d, sync %0d, video %0d, timeout %0d",
             err_reset, err_mode, err_sync, err_video, err_timeout);
    if (total == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+include
design/ppu_pkg.sv
design/ppu_cfg_ctrl.sv
design/scanline_emu.sv
design/rgb_range_out.sv
design/ppu_out_top.sv
test/ppu_out_tb.sv

// File: Makefile
# Verilator build and run of the post-processing output unit testbench

TOP       ?= ppu_out_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: TOP VERILATOR FLAGS OBJ_DIR"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f project.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
